//--- design/fpu_format_pkg.sv
`default_nettype none

package fpu_format_pkg;

    // ieee 754 single precision layout, msb first
    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] man;
    } fp32_fields_t;

    // same word seen either as a raw bus value or as its fields
    typedef union packed {
        logic [31:0]  raw;
        fp32_fields_t f;
    } fp32_u;

    // all ones exponent marks infinity and is also the saturation value
    localparam logic [7:0] EXP_MAX = 8'hff;

    // zero exponent is treated as zero, denormals are not supported
    localparam logic [7:0] EXP_ZERO = 8'h00;

    // 256 - 127, bit 8 of the biased sum then means no underflow
    // and bit 9 means overflow
    localparam logic [9:0] MUL_BIAS_ADJ = 10'd129;

    function automatic logic fp_is_zero(fp32_u x);
        return x.f.exp == EXP_ZERO;
    endfunction

    function automatic logic fp_is_inf(fp32_u x);
        return x.f.exp == EXP_MAX;
    endfunction

    // magnitude without the sign, orders like an unsigned integer
    function automatic logic [30:0] fp_mag(fp32_u x);
        return x.raw[30:0];
    endfunction

endpackage

`default_nettype wire

//--- design/fpu_op_pkg.sv
`default_nettype none

package fpu_op_pkg;

    import fpu_format_pkg::*;

    // request opcodes as seen on the top level port
    typedef enum logic [2:0] {
        OP_FMUL   = 3'd0,
        OP_FSGNJ  = 3'd1,
        OP_FSGNJN = 3'd2,
        OP_FSGNJX = 3'd3,
        OP_FEQ    = 3'd4,
        OP_FLT    = 3'd5,
        OP_FLE    = 3'd6
    } fpu_op_e;

    // sub-operations handled by the misc pipe
    typedef enum logic [2:0] {
        MISC_SGNJ  = 3'd0,
        MISC_SGNJN = 3'd1,
        MISC_SGNJX = 3'd2,
        MISC_EQ    = 3'd3,
        MISC_LT    = 3'd4,
        MISC_LE    = 3'd5
    } misc_op_e;

    typedef logic [3:0] fpu_tag_t;

    // 3 + 4 + 32 + 32 = 71 bits
    typedef struct packed {
        fpu_op_e  op;
        fpu_tag_t tag;
        fp32_u    a;
        fp32_u    b;
    } fpu_req_t;

    // 4 + 32 + 1 = 37 bits
    typedef struct packed {
        fpu_tag_t    tag;
        logic [31:0] value;
        logic        ovf;
    } fpu_rsp_t;

endpackage

`default_nettype wire

//--- design/fmul_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module fmul_pipe
    import fpu_format_pkg::*, fpu_op_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     in_valid,
    input  fpu_tag_t tag,
    input  fp32_u    a,
    input  fp32_u    b,
    output logic     out_valid,
    output fpu_rsp_t out
);

    // stage 1 registers, operands and split mantissas
    logic        v1;
    fpu_tag_t    tag1;
    fp32_u       a1;
    fp32_u       b1;
    logic [12:0] hi_a1;
    logic [10:0] lo_a1;
    logic [12:0] hi_b1;
    logic [10:0] lo_b1;

    // stage 2 registers, partial products
    logic        v2;
    fpu_tag_t    tag2;
    fp32_u       a2;
    fp32_u       b2;
    logic [25:0] hh2;
    logic [23:0] hl2;
    logic [23:0] lh2;

    // stage 3 registers, sign, raw exponent, truncated mantissa
    logic        v3;
    fpu_tag_t    tag3;
    logic        zero3;
    logic        inf3;
    logic        sign3;
    logic [9:0]  exp_raw3;
    logic [22:0] man3;
    logic [1:0]  lead3;

    logic [25:0] hh;
    logic [23:0] hl;
    logic [23:0] lh;
    logic [26:0] mmul;
    logic [22:0] man_trunc;
    logic [1:0]  lead;
    logic [9:0]  exp_raw;
    logic [8:0]  exp_sum;
    logic [7:0]  exp_fin;
    fp32_u       res;

    // cross products only keep their upper 13 bits, the +2 makes up
    // part of the dropped low*low term
    assign hh = hi_a1 * hi_b1;
    assign hl = hi_a1 * lo_b1;
    assign lh = lo_a1 * hi_b1;

    assign mmul = {1'b0, hh2} + {14'd0, hl2[23:11]} + {14'd0, lh2[23:11]} + 27'd2;

    // leading one lands in bit 26, 25 or 24 since both hidden bits are set
    assign lead = mmul[26] ? 2'd2 : (mmul[25] ? 2'd1 : 2'd0);
    assign man_trunc = mmul[26] ? mmul[25:3] :
                       mmul[25] ? mmul[24:2] :
                       mmul[24] ? mmul[23:1] : mmul[22:0];

    assign exp_raw = {2'b00, a2.f.exp} + {2'b00, b2.f.exp} + MUL_BIAS_ADJ;

    always_comb begin
        if (exp_raw3[9]) begin
            exp_sum = {1'b0, EXP_MAX};
        end else if (!exp_raw3[8]) begin
            exp_sum = {1'b0, EXP_ZERO};
        end else begin
            exp_sum = {1'b0, exp_raw3[7:0]} + {7'd0, lead3};
        end
        // carry out of the normalization step saturates as well
        exp_fin = exp_sum[8] ? EXP_MAX : exp_sum[7:0];

        res.f.sign = sign3;
        if (zero3) begin
            res.f.exp = EXP_ZERO;
            res.f.man = '0;
        end else if (inf3) begin
            res.f.exp = EXP_MAX;
            res.f.man = '0;
        end else begin
            res.f.exp = exp_fin;
            res.f.man = (exp_fin == EXP_MAX || exp_fin == EXP_ZERO) ? 23'd0 : man3;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            v1       <= 1'b0;
            v2       <= 1'b0;
            v3       <= 1'b0;
            tag1     <= '0;
            tag2     <= '0;
            tag3     <= '0;
            a1       <= '0;
            b1       <= '0;
            a2       <= '0;
            b2       <= '0;
            hi_a1    <= '0;
            lo_a1    <= '0;
            hi_b1    <= '0;
            lo_b1    <= '0;
            hh2      <= '0;
            hl2      <= '0;
            lh2      <= '0;
            zero3    <= 1'b0;
            inf3     <= 1'b0;
            sign3    <= 1'b0;
            exp_raw3 <= '0;
            man3     <= '0;
            lead3    <= '0;
        end else begin
            v1       <= in_valid;
            tag1     <= tag;
            a1       <= a;
            b1       <= b;
            hi_a1    <= {1'b1, a.f.man[22:11]};
            lo_a1    <= a.f.man[10:0];
            hi_b1    <= {1'b1, b.f.man[22:11]};
            lo_b1    <= b.f.man[10:0];

            v2       <= v1;
            tag2     <= tag1;
            a2       <= a1;
            b2       <= b1;
            hh2      <= hh;
            hl2      <= hl;
            lh2      <= lh;

            v3       <= v2;
            tag3     <= tag2;
            zero3    <= fp_is_zero(a2) | fp_is_zero(b2);
            inf3     <= fp_is_inf(a2) | fp_is_inf(b2);
            sign3    <= a2.f.sign ^ b2.f.sign;
            exp_raw3 <= exp_raw;
            man3     <= man_trunc;
            lead3    <= lead;
        end
    end

    assign out_valid = v3;
    assign out.tag   = tag3;
    assign out.value = res.raw;
    // overflow now leaves together with the saturated result it belongs to
    assign out.ovf   = !zero3 && !inf3 && (exp_fin == EXP_MAX);

    a_latency: assert property (@(posedge clk) disable iff (!rstn)
        out_valid == $past(in_valid, 3));

endmodule

`default_nettype wire

//--- design/fmisc_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module fmisc_pipe
    import fpu_format_pkg::*, fpu_op_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     in_valid,
    input  misc_op_e op,
    input  fpu_tag_t tag,
    input  fp32_u    a,
    input  fp32_u    b,
    output logic     out_valid,
    output fpu_rsp_t out
);

    logic [2:0] v_q;
    fpu_rsp_t   rsp_q [3];

    logic  both_zero;
    logic  is_eq;
    logic  is_lt;
    fp32_u res;

    // sign-magnitude compare, +0 and -0 are the same value
    assign both_zero = (fp_mag(a) == 31'd0) && (fp_mag(b) == 31'd0);
    assign is_eq     = (a.raw == b.raw) || both_zero;

    always_comb begin
        if (both_zero) begin
            is_lt = 1'b0;
        end else if (a.f.sign != b.f.sign) begin
            is_lt = a.f.sign;
        end else if (a.f.sign) begin
            // both negative, larger magnitude is the smaller number
            is_lt = fp_mag(a) > fp_mag(b);
        end else begin
            is_lt = fp_mag(a) < fp_mag(b);
        end
    end

    always_comb begin
        res.raw = a.raw;
        case (op)
            MISC_SGNJ:  res.f.sign = b.f.sign;
            MISC_SGNJN: res.f.sign = ~b.f.sign;
            MISC_SGNJX: res.f.sign = a.f.sign ^ b.f.sign;
            MISC_EQ:    res.raw = {31'd0, is_eq};
            MISC_LT:    res.raw = {31'd0, is_lt};
            MISC_LE:    res.raw = {31'd0, is_lt | is_eq};
            default:    res.raw = '0;
        endcase
    end

    // stages 2 and 3 only delay, matching the multiplier latency
    always_ff @(posedge clk) begin
        if (!rstn) begin
            v_q      <= '0;
            rsp_q[0] <= '0;
            rsp_q[1] <= '0;
            rsp_q[2] <= '0;
        end else begin
            v_q            <= {v_q[1:0], in_valid};
            rsp_q[0].tag   <= tag;
            rsp_q[0].value <= res.raw;
            rsp_q[0].ovf   <= 1'b0;
            rsp_q[1]       <= rsp_q[0];
            rsp_q[2]       <= rsp_q[1];
        end
    end

    assign out_valid = v_q[2];
    assign out       = rsp_q[2];

    a_no_ovf: assert property (@(posedge clk) disable iff (!rstn)
        in_valid |-> ##3 (out_valid && !out.ovf));

endmodule

`default_nettype wire

//--- design/fpu_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_ctrl
    import fpu_op_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     req_valid,
    input  fpu_req_t req,
    input  logic     clr_flags,
    output logic     mul_valid,
    output logic     misc_valid,
    output misc_op_e misc_op,
    input  logic     mul_rsp_valid,
    input  fpu_rsp_t mul_rsp,
    input  logic     misc_rsp_valid,
    input  fpu_rsp_t misc_rsp,
    output logic     rsp_valid,
    output fpu_rsp_t rsp,
    output logic     ovf_sticky
);

    logic is_mul;

    assign is_mul     = (req.op == OP_FMUL);
    assign mul_valid  = req_valid && is_mul;
    // every other encoding goes to the misc pipe so each request returns
    assign misc_valid = req_valid && !is_mul;

    always_comb begin
        case (req.op)
            OP_FSGNJ:  misc_op = MISC_SGNJ;
            OP_FSGNJN: misc_op = MISC_SGNJN;
            OP_FSGNJX: misc_op = MISC_SGNJX;
            OP_FEQ:    misc_op = MISC_EQ;
            OP_FLT:    misc_op = MISC_LT;
            OP_FLE:    misc_op = MISC_LE;
            default:   misc_op = MISC_SGNJ;
        endcase
    end

    // equal latency in both pipes, so at most one result per cycle
    assign rsp_valid = mul_rsp_valid || misc_rsp_valid;
    assign rsp       = mul_rsp_valid ? mul_rsp : misc_rsp;

    // a new overflow beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ovf_sticky <= 1'b0;
        end else if (rsp_valid && rsp.ovf) begin
            ovf_sticky <= 1'b1;
        end else if (clr_flags) begin
            ovf_sticky <= 1'b0;
        end
    end

    a_one_result: assert property (@(posedge clk) disable iff (!rstn)
        !(mul_rsp_valid && misc_rsp_valid));

endmodule

`default_nettype wire

//--- design/fpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_top
    import fpu_op_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     req_valid,
    input  fpu_req_t req,
    input  logic     clr_flags,
    output logic     rsp_valid,
    output fpu_rsp_t rsp,
    output logic     ovf_sticky
);

    logic     mul_valid;
    logic     misc_valid;
    misc_op_e misc_op;
    logic     mul_rsp_valid;
    fpu_rsp_t mul_rsp;
    logic     misc_rsp_valid;
    fpu_rsp_t misc_rsp;

    fpu_ctrl i_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .req_valid      (req_valid),
        .req            (req),
        .clr_flags      (clr_flags),
        .mul_valid      (mul_valid),
        .misc_valid     (misc_valid),
        .misc_op        (misc_op),
        .mul_rsp_valid  (mul_rsp_valid),
        .mul_rsp        (mul_rsp),
        .misc_rsp_valid (misc_rsp_valid),
        .misc_rsp       (misc_rsp),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .ovf_sticky     (ovf_sticky)
    );

    // tag and operands go to both pipes, only the strobes differ
    fmul_pipe i_mul (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (mul_valid),
        .tag       (req.tag),
        .a         (req.a),
        .b         (req.b),
        .out_valid (mul_rsp_valid),
        .out       (mul_rsp)
    );

    fmisc_pipe i_misc (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (misc_valid),
        .op        (misc_op),
        .tag       (req.tag),
        .a         (req.a),
        .b         (req.b),
        .out_valid (misc_rsp_valid),
        .out       (misc_rsp)
    );

endmodule

`default_nettype wire

//--- test/fpu_ref.svh
`ifndef FPU_REF_SVH
`define FPU_REF_SVH

// truncated split-mantissa product where the +2 constant stands in for low*low
function automatic fpu_rsp_t ref_fmul(fpu_tag_t tag, fp32_u a, fp32_u b);
    int unsigned hi_a;
    int unsigned lo_a;
    int unsigned hi_b;
    int unsigned lo_b;
    int unsigned prod;
    int unsigned man;
    int          lead;
    int          e;
    logic        zero;
    logic        inf;
    fpu_rsp_t    rsp;
    hi_a = 32'({1'b1, a.f.man[22:11]});
    lo_a = 32'(a.f.man[10:0]);
    hi_b = 32'({1'b1, b.f.man[22:11]});
    lo_b = 32'(b.f.man[10:0]);
    prod = hi_a * hi_b + ((hi_a * lo_b) >> 11) + ((lo_a * hi_b) >> 11) + 2;
    if (prod >= 32'h400_0000) begin
        lead = 2;
        man  = (prod >> 3) & 32'h7f_ffff;
    end else if (prod >= 32'h200_0000) begin
        lead = 1;
        man  = (prod >> 2) & 32'h7f_ffff;
    end else begin
        lead = 0;
        man  = (prod >> 1) & 32'h7f_ffff;
    end
    // biased result exponent before normalization
    e = int'(a.f.exp) + int'(b.f.exp) - 127;
    if (e >= 256) begin
        e = 255;
    end else if (e < 0) begin
        e = 0;
    end else begin
        e = e + lead;
        if (e > 255) begin
            e = 255;
        end
    end
    zero = (a.f.exp == 8'd0) || (b.f.exp == 8'd0);
    inf  = (a.f.exp == 8'd255) || (b.f.exp == 8'd255);
    rsp.tag        = tag;
    rsp.value[31]  = a.f.sign ^ b.f.sign;
    rsp.ovf        = 1'b0;
    if (zero) begin
        rsp.value[30:0] = 31'd0;
    end else if (inf) begin
        rsp.value[30:0] = {8'hff, 23'd0};
    end else begin
        rsp.value[30:23] = 8'(e);
        rsp.value[22:0]  = (e == 0 || e == 255) ? 23'd0 : 23'(man);
        rsp.ovf          = (e == 255);
    end
    return rsp;
endfunction

function automatic logic [31:0] ref_sgnj(fpu_op_e op, fp32_u a, fp32_u b);
    logic s;
    case (op)
        OP_FSGNJ:  s = b.f.sign;
        OP_FSGNJN: s = !b.f.sign;
        default:   s = a.f.sign ^ b.f.sign;
    endcase
    return {s, a.raw[30:0]};
endfunction

// maps each word to a signed integer key so that -0 and +0 both become 0
function automatic logic [31:0] ref_cmp(fpu_op_e op, fp32_u a, fp32_u b);
    int ka;
    int kb;
    ka = a.f.sign ? -int'(a.raw[30:0]) : int'(a.raw[30:0]);
    kb = b.f.sign ? -int'(b.raw[30:0]) : int'(b.raw[30:0]);
    case (op)
        OP_FEQ:  return {31'd0, ka == kb};
        OP_FLT:  return {31'd0, ka < kb};
        default: return {31'd0, ka <= kb};
    endcase
endfunction

`endif

//--- test/fpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fpu_tb
    import fpu_format_pkg::*, fpu_op_pkg::*;
();

    logic     clk;
    logic     rstn;
    logic     req_valid;
    fpu_req_t req;
    logic     clr_flags;
    logic     rsp_valid;
    fpu_rsp_t rsp;
    logic     ovf_sticky;

    fpu_rsp_t    exp_q [$];
    string       name_q [$];
    int          sent_q [$];
    fpu_rsp_t    last_rsp;
    string       cur_name;
    fpu_tag_t    next_tag = '0;
    int          cyc = 0;
    int          n_issued = 0;
    int          n_rsp = 0;
    fpu_op_e     sg_ops [3] = '{OP_FSGNJ, OP_FSGNJN, OP_FSGNJX};
    fpu_op_e     cmp_ops [3] = '{OP_FEQ, OP_FLT, OP_FLE};
    fpu_op_e     all_ops [7] = '{OP_FMUL, OP_FSGNJ, OP_FSGNJN, OP_FSGNJX, OP_FEQ, OP_FLT, OP_FLE};

    `include "fpu_ref.svh"

    fpu_top i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req        (req),
        .clr_flags  (clr_flags),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .ovf_sticky (ovf_sticky)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_val(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "check failed in %s", name);
        end
    endtask

    function automatic fpu_rsp_t expected_rsp(fpu_op_e op, fpu_tag_t tag, fp32_u a, fp32_u b);
        fpu_rsp_t r;
        r.tag = tag;
        r.ovf = 1'b0;
        case (op)
            OP_FMUL:                        r = ref_fmul(tag, a, b);
            OP_FSGNJ, OP_FSGNJN, OP_FSGNJX: r.value = ref_sgnj(op, a, b);
            default:                        r.value = ref_cmp(op, a, b);
        endcase
        return r;
    endfunction

    function automatic logic [31:0] rand_fp(int emin, int emax);
        fp32_u x;
        x.f.sign = 1'($urandom_range(1, 0));
        x.f.exp  = 8'($urandom_range(emax, emin));
        x.f.man  = 23'($urandom());
        return x.raw;
    endfunction

    // drives one request for a single cycle and records what should come back
    task automatic issue(string name, fpu_op_e op, logic [31:0] a, logic [31:0] b);
        fpu_req_t r;
        r.op  = op;
        r.tag = next_tag;
        r.a   = a;
        r.b   = b;
        req       = r;
        req_valid = 1'b1;
        exp_q.push_back(expected_rsp(op, next_tag, r.a, r.b));
        name_q.push_back(name);
        sent_q.push_back(cyc);
        next_tag = next_tag + 1'b1;
        n_issued++;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > 64) begin
                $display("Test failures found");
                $fatal(1, "timed out waiting for %0d outstanding responses", exp_q.size());
            end
        end
        @(posedge clk);
        #1;
    endtask

    // exact value compared without the mantissa lsb since the +2 term can set it
    task automatic mul_known(string name, logic [31:0] a, logic [31:0] b, logic [31:0] exact);
        issue(name, OP_FMUL, a, b);
        drain();
        check_val({name, " exact"}, 64'(exact >> 1), 64'(last_rsp.value >> 1));
    endtask

    task automatic cmp_pair(string name, logic [31:0] a, logic [31:0] b);
        for (int i = 0; i < 3; i++) begin
            issue(name, cmp_ops[i], a, b);
            issue(name, cmp_ops[i], b, a);
        end
    endtask

    // each response must match the oldest request and arrive three cycles after it
    always @(negedge clk) begin
        if (rstn && rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("Test failures found");
                $fatal(1, "response with tag %0d arrived with no request outstanding", rsp.tag);
            end else begin
                cur_name = name_q.pop_front();
                check_val(cur_name, 64'(exp_q.pop_front()), 64'(rsp));
                check_val({cur_name, " latency"}, 64'(sent_q.pop_front() + 3), 64'(cyc));
                last_rsp = rsp;
                n_rsp++;
            end
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        void'($urandom(32'h49e9_9b02));
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        clr_flags = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        check_val("sticky after reset", 64'd0, 64'(ovf_sticky));

        mul_known("fmul 1.5*2.0", 32'h3fc0_0000, 32'h4000_0000, 32'h4040_0000);
        mul_known("fmul 1.0*1.0", 32'h3f80_0000, 32'h3f80_0000, 32'h3f80_0000);
        mul_known("fmul -2.0*0.5", 32'hc000_0000, 32'h3f00_0000, 32'hbf80_0000);

        for (int i = 0; i < 300; i++) begin
            issue("fmul random normal", OP_FMUL, rand_fp(64, 190), rand_fp(64, 190));
        end
        drain();
        check_val("sticky after normal range", 64'd0, 64'(ovf_sticky));

        // zero wins when a zero and an infinite operand meet
        for (int i = 0; i < 20; i++) begin
            issue("fmul zero", OP_FMUL, rand_fp(0, 0), rand_fp(1, 254));
            issue("fmul inf", OP_FMUL, rand_fp(1, 254), rand_fp(255, 255));
            issue("fmul zero inf", OP_FMUL, rand_fp(255, 255), rand_fp(0, 0));
            issue("fmul underflow", OP_FMUL, rand_fp(1, 60), rand_fp(1, 60));
        end
        drain();
        check_val("sticky after specials", 64'd0, 64'(ovf_sticky));

        issue("fmul overflow", OP_FMUL, 32'h7e00_0000, 32'h7e00_0000);
        drain();
        check_val("overflow value", 64'h7f80_0000, 64'(last_rsp.value));
        check_val("overflow flag", 64'd1, 64'(last_rsp.ovf));
        check_val("sticky after overflow", 64'd1, 64'(ovf_sticky));
        clr_flags = 1'b1;
        @(posedge clk);
        #1;
        clr_flags = 1'b0;
        check_val("sticky after clear", 64'd0, 64'(ovf_sticky));
        issue("fmul flush", OP_FMUL, 32'h8100_0000, 32'h0100_0000);
        drain();
        check_val("flush value", 64'h8000_0000, 64'(last_rsp.value));
        check_val("flush flag", 64'd0, 64'(last_rsp.ovf));
        check_val("sticky stays low", 64'd0, 64'(ovf_sticky));

        for (int i = 0; i < 100; i++) begin
            issue("fmul random wide", OP_FMUL, rand_fp(1, 254), rand_fp(1, 254));
            issue("fmul random large", OP_FMUL, rand_fp(160, 254), rand_fp(160, 254));
        end
        drain();

        for (int i = 0; i < 100; i++) begin
            issue("sgnj random", sg_ops[$urandom_range(2, 0)], $urandom(), $urandom());
        end
        drain();

        cmp_pair("cmp +0 -0", 32'h0000_0000, 32'h8000_0000);
        cmp_pair("cmp equal", 32'h3fc0_0000, 32'h3fc0_0000);
        cmp_pair("cmp neg pos", 32'hbf80_0000, 32'h4000_0000);
        cmp_pair("cmp neg neg", 32'hbf80_0000, 32'hc000_0000);
        for (int i = 0; i < 150; i++) begin
            a = rand_fp(0, 255);
            case ($urandom_range(2, 0))
                0:       b = a;
                1:       b = a ^ 32'h8000_0000;
                default: b = rand_fp(0, 255);
            endcase
            issue("cmp random", cmp_ops[$urandom_range(2, 0)], a, b);
        end
        drain();

        // back to back mixed opcodes with sixteen distinct tags
        for (int i = 0; i < 16; i++) begin
            issue("burst", all_ops[$urandom_range(6, 0)], rand_fp(100, 150), rand_fp(100, 150));
        end
        drain();
        repeat (8) @(posedge clk);

        if (exp_q.size() != 0 || n_rsp != n_issued) begin
            $display("Test failures found");
            $fatal(1, "%0d requests issued but %0d responses seen", n_issued, n_rsp);
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+test
design/fpu_format_pkg.sv
design/fpu_op_pkg.sv
design/fmul_pipe.sv
design/fmisc_pipe.sv
design/fpu_ctrl.sv
design/fpu_top.sv
test/fpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module fpu_tb -o fpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/fpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi

exit 0
